// File: hdl/st_glue_params.svh
// shared widths and constants for the ST glue logic
// used by the RTL and the testbench alike
`ifndef ST_GLUE_PARAMS_SVH
`define ST_GLUE_PARAMS_SVH

// chipset word address, bits 23:1
`define SG_WORD_ADDR_W 23

// SD sector number
`define SG_LBA_W 32

// raw chipset audio and extended output samples
`define SG_AUDIO_IN_W 15
`define SG_AUDIO_W 16

// keyboard matrix columns driven by the chipset
`define SG_KBD_COLS 15

// boot wait for the SD image, 2 s at 32 MHz
`define SG_SD_WAIT_CYCLES 64_000_000

`endif

// File: hdl/st_glue_pkg.sv
// types shared by the ST glue blocks
// DB9 pin views, input words and config enums
`default_nettype none

package st_glue_pkg;

  // atari pin order, msb is io[5]
  typedef struct packed {
    logic fire2;
    logic left;
    logic right;
    logic up;
    logic down;
    logic fire;
  } db9_atari_t;

  // amiga swaps up and right against atari
  typedef struct packed {
    logic fire2;
    logic left;
    logic up;
    logic right;
    logic down;
    logic fire;
  } db9_amiga_t;

  // one inverted io word, decoded in both pin orders
  typedef union packed {
    db9_atari_t atari;
    db9_amiga_t amiga;
  } db9_port_t;

  typedef logic [5:0] joy6_t;  // {fire2, fire, up, down, left, right}
  typedef logic [7:0] kbd_row_t;  // active low keys

  typedef enum logic [1:0] {
    pm_usb       = 2'd0,
    pm_db9_atari = 2'd1,
    pm_db9_amiga = 2'd2,
    pm_none      = 2'd3
  } port_mouse_t;

  typedef enum logic [1:0] {
    vol_mute    = 2'd0,
    vol_quarter = 2'd1,
    vol_half    = 2'd2,
    vol_full    = 2'd3
  } volume_t;

endpackage

`default_nettype wire

// File: hdl/sd_req_if.sv
// one requester's SD sector request bundle
// nonzero rd or wr is a request strobe, no handshake
`timescale 1ns/10ps
`default_nettype none
`include "st_glue_params.svh"

interface sd_req_if;

  logic [1:0]           rd;  // per drive read request
  logic [1:0]           wr;  // per drive write request
  logic [`SG_LBA_W-1:0] lba;  // sector number
  logic [7:0]           wr_byte;  // sector data towards the card

  // requester drives everything
  modport req (output rd, output wr, output lba, output wr_byte);

  // arbiter only looks
  modport arb (input rd, input wr, input lba, input wr_byte);

endinterface

`default_nettype wire

// File: hdl/boot_gate.sv
// boot gate: holds the chipset in reset until memories and the SD image are ready
// sd_ready comes from image presence or a wait timer, whichever is first
`timescale 1ns/10ps
`default_nettype none
`include "st_glue_params.svh"

module boot_gate #(
  parameter int unsigned WAIT_CYCLES = `SG_SD_WAIT_CYCLES
) (
  input  wire logic        clk32,
  input  wire logic        rst,
  input  wire logic [31:0] img_size,  // nonzero once an image is mounted
  input  wire logic        ram_ready,
  input  wire logic        flash_ready,
  input  wire logic        reset_button,  // user button, active high
  input  wire logic        coldboot_reset,  // system reset flag
  output logic             chip_reset_n
);

  logic [31:0] sd_wait;  // cycles spent waiting
  logic        sd_ready;

  always_ff @(posedge clk32) begin
    if (rst) begin
      sd_wait  <= 32'd0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (img_size != 32'd0)
        sd_ready <= 1'b1;  // mcu mounted an image
      if (sd_wait < 32'(WAIT_CYCLES))
        sd_wait <= sd_wait + 32'd1;
      else
        sd_ready <= 1'b1;  // gave up waiting, boot anyway
    end
  end

  // any missing condition keeps the chipset in reset
  assign chip_reset_n = sd_ready & ram_ready & flash_ready & ~reset_button & ~coldboot_reset;

  // ready is sticky until the next reset
  a_sd_ready_sticky: assert property (@(posedge clk32) sd_ready && !rst |=> sd_ready);

endmodule

`default_nettype wire

// File: hdl/ram_scrambler.sv
// cold-boot RAM scrambler: steps a 2-bit key on each coldboot rising edge
// key is xor'ed into word address bits 4:3, also forms the RAM chip select
`timescale 1ns/10ps
`default_nettype none
`include "st_glue_params.svh"

module ram_scrambler (
  input  wire logic                        clk32,
  input  wire logic                        rst,
  input  wire logic                        coldboot,  // coldboot flag
  input  wire logic [`SG_WORD_ADDR_W:1]    ram_addr,  // chipset word address
  input  wire logic                        ras_n,
  output logic      [`SG_WORD_ADDR_W-1:1]  ram_addr_s,  // scrambled, 8MB window
  output logic                             ram_cs
);

  logic       cb_d;  // coldboot delayed for edge detect
  logic [1:0] ram_scramble;

  always_ff @(posedge clk32) begin
    if (rst) begin
      cb_d         <= 1'b0;
      ram_scramble <= 2'd0;
    end else begin
      cb_d <= coldboot;
      if (coldboot && !cb_d)
        ram_scramble <= ram_scramble + 2'd1;  // wraps after four boots
    end
  end

  // old contents land on different words after a cold boot
  assign ram_addr_s = {ram_addr[`SG_WORD_ADDR_W-1:5], ram_addr[4:3] ^ ram_scramble,
                       ram_addr[2:1]};

  // top address bit is outside the ram
  assign ram_cs = ~ras_n & ~ram_addr[`SG_WORD_ADDR_W];

endmodule

`default_nettype wire

// File: hdl/input_mux.sv
// input mixing: DB9 decode, mouse/joystick port selection, keyboard matrix scan
// purely combinational
`timescale 1ns/10ps
`default_nettype none
`include "st_glue_params.svh"

module input_mux (
  input  wire st_glue_pkg::port_mouse_t                  port_mouse,
  input  wire logic [5:0]                                io,  // DB9 pins, active low
  input  wire st_glue_pkg::joy6_t                        hid_mouse,
  input  wire logic [7:0]                                hid_joy,
  input  wire st_glue_pkg::kbd_row_t [`SG_KBD_COLS-1:0]  kbd_matrix,
  input  wire logic [`SG_KBD_COLS-1:0]                   kbd_col_sel,  // active low
  output st_glue_pkg::joy6_t                             joy0,
  output logic      [4:0]                                joy1,
  output st_glue_pkg::kbd_row_t                          kbd_row_out
);

  import st_glue_pkg::*;

  db9_port_t db9;
  joy6_t     db9_atari;
  joy6_t     db9_amiga;

  assign db9 = ~io;  // pins pull low when active

  // same word, two pin orders, both into chipset order
  assign db9_atari = {db9.atari.fire2, db9.atari.fire, db9.atari.up, db9.atari.down,
                      db9.atari.left, db9.atari.right};
  assign db9_amiga = {db9.amiga.fire2, db9.amiga.fire, db9.amiga.up, db9.amiga.down,
                      db9.amiga.left, db9.amiga.right};

  // a db9 mouse replaces usb, mice hold lines active so no wiring together
  always_comb begin
    case (port_mouse)
      pm_usb:       joy0 = hid_mouse;
      pm_db9_atari: joy0 = db9_atari;
      pm_db9_amiga: joy0 = db9_amiga;
      default:      joy0 = '0;
    endcase
  end

  // db9 doubles as joystick only while the mouse is on usb
  assign joy1 = (port_mouse == pm_usb) ? (hid_joy[4:0] | db9_atari[4:0]) : hid_joy[4:0];

  // selected columns pull their pressed keys low
  always_comb begin
    kbd_row_out = 8'hff;  // nothing selected, nothing pressed
    for (int c = 0; c < `SG_KBD_COLS; c++) begin
      if (!kbd_col_sel[c])
        kbd_row_out = kbd_row_out & kbd_matrix[c];
    end
  end

endmodule

`default_nettype wire

// File: hdl/audio_volume.sv
// audio volume: sign-extends both 15-bit channels and scales them
// mute, quarter, half or full, one register stage
`timescale 1ns/10ps
`default_nettype none
`include "st_glue_params.svh"

module audio_volume (
  input  wire logic                    clk32,
  input  wire logic                    rst,
  input  wire logic [`SG_AUDIO_IN_W-1:0] audio_l,
  input  wire logic [`SG_AUDIO_IN_W-1:0] audio_r,
  input  wire st_glue_pkg::volume_t      volume,
  output logic      [`SG_AUDIO_W-1:0]    audio_out_l,
  output logic      [`SG_AUDIO_W-1:0]    audio_out_r
);

  import st_glue_pkg::*;

  // signed division by shifting, sign bit copied in from the top
  function automatic logic [`SG_AUDIO_W-1:0] scale(input logic [`SG_AUDIO_IN_W-1:0] smp,
                                                   input volume_t vol);
    logic [`SG_AUDIO_W-1:0] s16;
    s16 = {smp[`SG_AUDIO_IN_W-1], smp};  // one extra sign bit
    case (vol)
      vol_mute:    scale = '0;
      vol_quarter: scale = {{2{s16[`SG_AUDIO_W-1]}}, s16[`SG_AUDIO_W-1:2]};
      vol_half:    scale = {s16[`SG_AUDIO_W-1], s16[`SG_AUDIO_W-1:1]};
      default:     scale = s16;
    endcase
  endfunction

  always_ff @(posedge clk32) begin
    if (rst) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
    end else begin
      audio_out_l <= scale(audio_l, volume);
      audio_out_r <= scale(audio_r, volume);
    end
  end

endmodule

`default_nettype wire

// File: hdl/sd_arbiter.sv
// SD request arbiter: remembers whether ACSI or the floppy asked last
// routes sector number and write byte of that side to the card
`timescale 1ns/10ps
`default_nettype none
`include "st_glue_params.svh"

module sd_arbiter (
  input  wire logic          clk32,
  input  wire logic          rst,
  sd_req_if.arb              acsi,  // hard disk side
  sd_req_if.arb              fdc,  // floppy side
  output logic [3:0]         sd_rstart,  // {acsi, fdc}
  output logic [3:0]         sd_wstart,
  output logic [`SG_LBA_W-1:0] sd_lba,
  output logic [7:0]         sd_wr_byte
);

  logic acsi_req;
  logic fdc_req;
  logic is_acsi_d;  // last request came from acsi
  logic is_acsi;

  assign acsi_req = (acsi.rd != 2'b00) || (acsi.wr != 2'b00);
  assign fdc_req  = (fdc.rd != 2'b00) || (fdc.wr != 2'b00);

  always_ff @(posedge clk32) begin
    if (rst) begin
      is_acsi_d <= 1'b0;  // floppy owns the card by default
    end else begin
      if (acsi_req)
        is_acsi_d <= 1'b1;
      if (fdc_req)
        is_acsi_d <= 1'b0;
    end
  end

  // new acsi request wins in its own cycle, before the latch catches up
  assign is_acsi = acsi_req | is_acsi_d;

  assign sd_rstart = {acsi.rd, fdc.rd};
  assign sd_wstart = {acsi.wr, fdc.wr};

  assign sd_lba     = is_acsi ? acsi.lba : fdc.lba;
  assign sd_wr_byte = is_acsi ? acsi.wr_byte : fdc.wr_byte;  // card pulls bytes later

  // both controllers share the one card, chipset never overlaps them
  a_no_dual_req: assert property (@(posedge clk32) disable iff (rst) !(acsi_req && fdc_req));

endmodule

`default_nettype wire

// File: hdl/st_glue_top.sv
// ST glue top: boot gating, RAM scrambling, input mixing, audio volume
// and SD request arbitration side by side around the chipset
`timescale 1ns/10ps
`default_nettype none
`include "st_glue_params.svh"

module st_glue_top #(
  parameter int unsigned WAIT_CYCLES = `SG_SD_WAIT_CYCLES
) (
  input  wire logic                                      clk32,
  input  wire logic                                      rst,
  // boot gating
  input  wire logic [31:0]                               img_size,
  input  wire logic                                      ram_ready,
  input  wire logic                                      flash_ready,
  input  wire logic                                      reset_button,
  input  wire logic [1:0]                                coldboot,  // {coldboot, reset}
  output logic                                           chip_reset_n,
  // ram
  input  wire logic [`SG_WORD_ADDR_W:1]                  ram_addr,
  input  wire logic                                      ras_n,
  output logic      [`SG_WORD_ADDR_W-1:1]                ram_addr_s,
  output logic                                           ram_cs,
  // inputs
  input  wire logic [5:0]                                io,
  input  wire st_glue_pkg::port_mouse_t                  port_mouse,
  input  wire st_glue_pkg::joy6_t                        hid_mouse,
  input  wire logic [7:0]                                hid_joy,
  output st_glue_pkg::joy6_t                             joy0,
  output logic      [4:0]                                joy1,
  input  wire st_glue_pkg::kbd_row_t [`SG_KBD_COLS-1:0]  kbd_matrix,
  input  wire logic [`SG_KBD_COLS-1:0]                   kbd_col_sel,
  output st_glue_pkg::kbd_row_t                          kbd_row_out,
  // audio
  input  wire logic [`SG_AUDIO_IN_W-1:0]                 audio_l,
  input  wire logic [`SG_AUDIO_IN_W-1:0]                 audio_r,
  input  wire st_glue_pkg::volume_t                      volume,
  output logic      [`SG_AUDIO_W-1:0]                    audio_out_l,
  output logic      [`SG_AUDIO_W-1:0]                    audio_out_r,
  // sd requests
  input  wire logic [1:0]                                acsi_rd,
  input  wire logic [1:0]                                acsi_wr,
  input  wire logic [`SG_LBA_W-1:0]                      acsi_lba,
  input  wire logic [7:0]                                acsi_wr_byte,
  input  wire logic [1:0]                                fdc_rd,
  input  wire logic [1:0]                                fdc_wr,
  input  wire logic [`SG_LBA_W-1:0]                      fdc_lba,
  input  wire logic [7:0]                                fdc_wr_byte,
  output logic      [3:0]                                sd_rstart,
  output logic      [3:0]                                sd_wstart,
  output logic      [`SG_LBA_W-1:0]                      sd_lba,
  output logic      [7:0]                                sd_wr_byte
);

  sd_req_if acsi_bus ();
  sd_req_if fdc_bus ();

  // requester sides filled straight from the pins
  assign acsi_bus.rd      = acsi_rd;
  assign acsi_bus.wr      = acsi_wr;
  assign acsi_bus.lba     = acsi_lba;
  assign acsi_bus.wr_byte = acsi_wr_byte;
  assign fdc_bus.rd       = fdc_rd;
  assign fdc_bus.wr       = fdc_wr;
  assign fdc_bus.lba      = fdc_lba;
  assign fdc_bus.wr_byte  = fdc_wr_byte;

  boot_gate #(.WAIT_CYCLES(WAIT_CYCLES)) i_boot_gate (
    .clk32          (clk32),
    .rst            (rst),
    .img_size       (img_size),
    .ram_ready      (ram_ready),
    .flash_ready    (flash_ready),
    .reset_button   (reset_button),
    .coldboot_reset (coldboot[0]),  // plain reset flag
    .chip_reset_n   (chip_reset_n)
  );

  ram_scrambler i_ram_scrambler (
    .clk32      (clk32),
    .rst        (rst),
    .coldboot   (coldboot[1]),  // coldboot request flag
    .ram_addr   (ram_addr),
    .ras_n      (ras_n),
    .ram_addr_s (ram_addr_s),
    .ram_cs     (ram_cs)
  );

  input_mux i_input_mux (
    .port_mouse  (port_mouse),
    .io          (io),
    .hid_mouse   (hid_mouse),
    .hid_joy     (hid_joy),
    .kbd_matrix  (kbd_matrix),
    .kbd_col_sel (kbd_col_sel),
    .joy0        (joy0),
    .joy1        (joy1),
    .kbd_row_out (kbd_row_out)
  );

  audio_volume i_audio_volume (
    .clk32       (clk32),
    .rst         (rst),
    .audio_l     (audio_l),
    .audio_r     (audio_r),
    .volume      (volume),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r)
  );

  sd_arbiter i_sd_arbiter (
    .clk32      (clk32),
    .rst        (rst),
    .acsi       (acsi_bus.arb),
    .fdc        (fdc_bus.arb),
    .sd_rstart  (sd_rstart),
    .sd_wstart  (sd_wstart),
    .sd_lba     (sd_lba),
    .sd_wr_byte (sd_wr_byte)
  );

endmodule

`default_nettype wire

// File: tests/tb_st_glue.sv
// testbench for the ST glue top level
// table-driven checks of boot gating, scrambling, input mixing, audio and SD routing
`timescale 1ns/10ps
`default_nettype none
`include "st_glue_params.svh"

module tb_st_glue;

  import st_glue_pkg::*;

  localparam int WAIT    = 20;  // short boot wait for simulation
  localparam int TIMEOUT = 200;  // cycles, per wait loop
  localparam int N_AUD   = 8;

  typedef struct packed {
    logic [1:0]              mode;
    logic [5:0]              io;
    logic [5:0]              mouse;
    logic [7:0]              joy;
    logic [`SG_KBD_COLS-1:0] col_sel;
    logic [5:0]              joy0;  // expected
    logic [4:0]              joy1;  // expected
  } mix_vec_t;

  typedef struct packed {
    logic [1:0] acsi_rd;
    logic [1:0] acsi_wr;
    logic [1:0] fdc_rd;
    logic [1:0] fdc_wr;
    logic [3:0] rstart;  // expected {acsi, fdc}
    logic [3:0] wstart;
    logic       from_acsi;  // expected routing
  } sd_vec_t;

  // mode, io pins (active low), hid mouse, hid joy, column select, joy0, joy1
  localparam mix_vec_t MIX_TAB [11] = '{
    {2'd0, 6'h3f, 6'h15, 8'ha3, 15'h7fff, 6'h15, 5'h03},  // idle pins, usb mouse
    {2'd0, 6'h3e, 6'h2a, 8'h01, 15'h7ffe, 6'h2a, 5'h11},  // db9 fire joins hid joy
    {2'd0, 6'h3b, 6'h00, 8'h00, 15'h0000, 6'h00, 5'h08},  // atari up
    {2'd1, 6'h1f, 6'h3f, 8'hff, 15'h5aa5, 6'h20, 5'h1f},  // fire2 as mouse button
    {2'd1, 6'h3b, 6'h00, 8'h04, 15'h3ffb, 6'h08, 5'h04},
    {2'd2, 6'h3b, 6'h00, 8'h10, 15'h7f7f, 6'h01, 5'h10},  // same pin is amiga right
    {2'd2, 6'h37, 6'h11, 8'h60, 15'h0f0f, 6'h08, 5'h00},  // amiga up
    {2'd2, 6'h2d, 6'h00, 8'h0a, 15'h7ffd, 6'h06, 5'h0a},  // left and down
    {2'd3, 6'h00, 6'h3f, 8'h1b, 15'h4001, 6'h00, 5'h1b},  // no mouse port
    {2'd0, 6'h00, 6'h11, 8'h00, 15'h1234, 6'h11, 5'h1f},  // every pin active
    {2'd0, 6'h37, 6'h3f, 8'h02, 15'h6ffe, 6'h3f, 5'h03}   // atari right
  };

  // acsi rd, acsi wr, fdc rd, fdc wr, rstart, wstart, acsi side routed
  localparam sd_vec_t SD_TAB [10] = '{
    {2'b00, 2'b00, 2'b00, 2'b00, 4'b0000, 4'b0000, 1'b0},  // floppy owns card
    {2'b01, 2'b00, 2'b00, 2'b00, 4'b0100, 4'b0000, 1'b1},  // acsi wins at once
    {2'b00, 2'b00, 2'b00, 2'b00, 4'b0000, 4'b0000, 1'b1},
    {2'b00, 2'b00, 2'b00, 2'b00, 4'b0000, 4'b0000, 1'b1},
    {2'b00, 2'b00, 2'b00, 2'b10, 4'b0000, 4'b0010, 1'b1},  // latch still acsi
    {2'b00, 2'b00, 2'b00, 2'b00, 4'b0000, 4'b0000, 1'b0},
    {2'b00, 2'b11, 2'b00, 2'b00, 4'b0000, 4'b1100, 1'b1},
    {2'b00, 2'b00, 2'b01, 2'b00, 4'b0001, 4'b0000, 1'b1},
    {2'b00, 2'b00, 2'b00, 2'b00, 4'b0000, 4'b0000, 1'b0},
    {2'b00, 2'b00, 2'b10, 2'b00, 4'b0010, 4'b0000, 1'b0}
  };

  logic clk32, rst;
  logic [31:0] img_size;
  logic ram_ready, flash_ready, reset_button, chip_reset_n;
  logic [1:0] coldboot;
  logic [`SG_WORD_ADDR_W:1] ram_addr;
  logic [`SG_WORD_ADDR_W-1:1] ram_addr_s;
  logic ras_n, ram_cs;
  logic [5:0] io;
  port_mouse_t port_mouse;
  joy6_t hid_mouse, joy0;
  logic [7:0] hid_joy;
  logic [4:0] joy1;
  kbd_row_t [`SG_KBD_COLS-1:0] kbd_matrix;
  logic [`SG_KBD_COLS-1:0] kbd_col_sel;
  kbd_row_t kbd_row_out;
  logic [`SG_AUDIO_IN_W-1:0] audio_l, audio_r;
  volume_t volume;
  logic [`SG_AUDIO_W-1:0] audio_out_l, audio_out_r;
  logic [1:0] acsi_rd, acsi_wr, fdc_rd, fdc_wr;
  logic [`SG_LBA_W-1:0] acsi_lba, fdc_lba, sd_lba;
  logic [7:0] acsi_wr_byte, fdc_wr_byte, sd_wr_byte;
  logic [3:0] sd_rstart, sd_wstart;

  logic [15:0] lfsr;  // galois state
  int checks, errors, t_checks, t_errors;

  st_glue_top #(.WAIT_CYCLES(WAIT)) i_dut (.*);

  initial begin
    clk32 = 1'b0;
    forever #50 clk32 = ~clk32;  // 100 ns period
  end

  // one lfsr step per bit taken, taps 16,14,13,11
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
        lfsr = lfsr ^ 16'hb400;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - t_checks, errors - t_errors);
    t_checks = checks;
    t_errors = errors;
  endtask

  // rst high for 3 rising edges, returns mid-cycle after release
  task automatic apply_reset();
    @(posedge clk32);
    rst <= 1'b1;
    repeat (3) @(posedge clk32);
    rst <= 1'b0;
    @(negedge clk32);
  endtask

  // counts rising edges until the chipset leaves reset, gives up after TIMEOUT
  task automatic wait_chip_running(output int cycles);
    cycles = 0;
    while (chip_reset_n !== 1'b1 && cycles < TIMEOUT) begin
      @(posedge clk32);
      cycles++;
      @(negedge clk32);
    end
    if (chip_reset_n !== 1'b1) begin
      errors++;
      $display("Timeout at %0t ns: chip_reset_n never went high", $time);
    end
  endtask

  // AND of every row whose column select is low
  function automatic kbd_row_t expected_row(input logic [`SG_KBD_COLS-1:0] sel);
    kbd_row_t row;
    row = 8'hff;
    for (int c = 0; c < `SG_KBD_COLS; c++) begin
      if (sel[c] == 1'b0)
        row = row & kbd_matrix[c];
    end
    return row;
  endfunction

  // signed sample scaled by 0, 1/4, 1/2 or 1, rounding toward minus infinity
  function automatic logic [15:0] scaled(input logic [14:0] smp, input int vol);
    int v;
    v = int'($signed(smp));
    case (vol)
      0: v = 0;
      1: v = v >>> 2;
      2: v = v >>> 1;
      default: ;
    endcase
    return 16'(v);
  endfunction

  initial begin
    int cycles, cb_count;
    logic [`SG_WORD_ADDR_W:1] addr;
    logic [`SG_WORD_ADDR_W-1:1] exp_addr;
    logic ras;
    logic [14:0] samples [N_AUD];
    logic [15:0] exp_l, exp_r;
    logic [31:0] a_lba, f_lba;
    logic [7:0] a_byte, f_byte;
    mix_vec_t mv;
    sd_vec_t sv;

    lfsr = 16'd52213;
    checks = 0;
    errors = 0;
    t_checks = 0;
    t_errors = 0;
    rst = 1'b1;
    img_size = '0;
    ram_ready = 1'b1;
    flash_ready = 1'b1;
    reset_button = 1'b0;
    coldboot = 2'b00;
    ram_addr = '0;
    ras_n = 1'b1;
    io = 6'h3f;  // nothing pressed
    port_mouse = pm_usb;
    hid_mouse = '0;
    hid_joy = '0;
    kbd_matrix = '1;
    kbd_col_sel = '1;
    audio_l = '0;
    audio_r = '0;
    volume = vol_full;
    acsi_rd = '0;
    acsi_wr = '0;
    acsi_lba = '0;
    acsi_wr_byte = '0;
    fdc_rd = '0;
    fdc_wr = '0;
    fdc_lba = '0;
    fdc_wr_byte = '0;

    // boot wait, no image so the timer decides
    apply_reset();
    wait_chip_running(cycles);
    check_value("boot wait cycles", 32'(cycles), 32'(WAIT + 1));
    apply_reset();
    check_value("chip_reset_n", 32'(chip_reset_n), 32'd0);
    @(posedge clk32);
    img_size <= 32'h0004_0000;  // image mounted
    @(negedge clk32);
    check_value("chip_reset_n", 32'(chip_reset_n), 32'd0);
    wait_chip_running(cycles);
    check_value("image ready cycles", 32'(cycles), 32'd1);
    @(posedge clk32);
    reset_button <= 1'b1;
    @(negedge clk32);
    check_value("chip_reset_n", 32'(chip_reset_n), 32'd0);  // same cycle
    @(posedge clk32);
    reset_button <= 1'b0;
    img_size <= '0;
    @(negedge clk32);
    check_value("chip_reset_n", 32'(chip_reset_n), 32'd1);  // ready is sticky
    report_test("boot wait");

    // cold-boot scrambling, key counts coldboot pulses
    cb_count = 0;
    for (int p = 0; p < 6; p++) begin
      for (int a = 0; a < 4; a++) begin
        addr = 23'(random_bits(23));
        ras  = 1'(random_bits(1));
        @(posedge clk32);
        ram_addr <= addr;
        ras_n    <= ras;
        @(negedge clk32);
        exp_addr      = addr[`SG_WORD_ADDR_W-1:1];
        exp_addr[4:3] = exp_addr[4:3] ^ 2'(cb_count);
        check_value("ram_addr_s", 32'(ram_addr_s), 32'(exp_addr));
        // selected only for a low strobe inside the lower 8 MB
        check_value("ram_cs", 32'(ram_cs),
                    (ras == 1'b0 && addr[`SG_WORD_ADDR_W] == 1'b0) ? 32'd1 : 32'd0);
      end
      @(posedge clk32);
      coldboot <= 2'b10;  // one-cycle pulse
      @(posedge clk32);
      coldboot <= 2'b00;
      cb_count++;
    end
    report_test("cold-boot scrambling");

    // input mixing
    @(posedge clk32);
    for (int c = 0; c < `SG_KBD_COLS; c++)
      kbd_matrix[c] <= 8'(random_bits(8));
    for (int i = 0; i < 11; i++) begin
      mv = MIX_TAB[i];
      @(posedge clk32);
      port_mouse  <= port_mouse_t'(mv.mode);
      io          <= mv.io;
      hid_mouse   <= mv.mouse;
      hid_joy     <= mv.joy;
      kbd_col_sel <= mv.col_sel;
      @(negedge clk32);
      check_value("joy0", 32'(joy0), 32'(mv.joy0));
      check_value("joy1", 32'(joy1), 32'(mv.joy1));
      check_value("kbd_row_out", 32'(kbd_row_out), 32'(expected_row(mv.col_sel)));
    end
    report_test("input mixing");

    // audio volume, edge samples first then random ones
    samples[0] = 15'h4000;  // most negative
    samples[1] = 15'h7fff;  // minus one
    samples[2] = 15'h3fff;
    samples[3] = 15'h0003;
    for (int i = 4; i < N_AUD; i++)
      samples[i] = 15'(random_bits(15));
    exp_l = '0;
    exp_r = '0;
    for (int vi = 0; vi < 4; vi++) begin
      for (int i = 0; i < N_AUD; i++) begin
        @(posedge clk32);
        audio_l <= samples[i];
        audio_r <= samples[(i + 3) % N_AUD];
        volume  <= volume_t'(2'(vi));
        @(negedge clk32);
        check_value("audio_out_l", 32'(audio_out_l), 32'(exp_l));  // previous sample
        check_value("audio_out_r", 32'(audio_out_r), 32'(exp_r));
        exp_l = scaled(samples[i], vi);
        exp_r = scaled(samples[(i + 3) % N_AUD], vi);
      end
    end
    @(posedge clk32);
    @(negedge clk32);
    check_value("audio_out_l", 32'(audio_out_l), 32'(exp_l));
    check_value("audio_out_r", 32'(audio_out_r), 32'(exp_r));
    report_test("audio volume");

    // sd arbitration, fresh sector data each cycle
    for (int i = 0; i < 10; i++) begin
      sv     = SD_TAB[i];
      a_lba  = random_bits(32);
      f_lba  = random_bits(32);
      a_byte = 8'(random_bits(8));
      f_byte = 8'(random_bits(8));
      @(posedge clk32);
      acsi_rd      <= sv.acsi_rd;
      acsi_wr      <= sv.acsi_wr;
      fdc_rd       <= sv.fdc_rd;
      fdc_wr       <= sv.fdc_wr;
      acsi_lba     <= a_lba;
      fdc_lba      <= f_lba;
      acsi_wr_byte <= a_byte;
      fdc_wr_byte  <= f_byte;
      @(negedge clk32);
      check_value("sd_rstart", 32'(sd_rstart), 32'(sv.rstart));
      check_value("sd_wstart", 32'(sd_wstart), 32'(sv.wstart));
      check_value("sd_lba", sd_lba, sv.from_acsi ? a_lba : f_lba);
      check_value("sd_wr_byte", 32'(sd_wr_byte), 32'(sv.from_acsi ? a_byte : f_byte));
    end
    report_test("sd arbitration");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/st_glue_pkg.sv
hdl/sd_req_if.sv
hdl/boot_gate.sv
hdl/ram_scrambler.sv
hdl/input_mux.sv
hdl/audio_volume.sv
hdl/sd_arbiter.sv
hdl/st_glue_top.sv
tests/tb_st_glue.sv

// File: Makefile
# Verilator build and run for the ST glue testbench

VERILATOR ?= verilator
TOP       ?= tb_st_glue
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SRCS := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
